// ==== src.f ====
design/cpu_pkg.sv
design/program_mem.sv
design/cpu_control.sv
design/cpu_datapath.sv
design/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f src.f -o cpu_tb_sim \
  && ./obj_dir/cpu_tb_sim > sim.log \
  ; cat sim.log 2>/dev/null \
  ; grep -q "TEST RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tb/cpu_tb.sv ====
/*
  cpu testbench: loads short programs, runs them and checks the
  OUT stream against results worked out from the instruction rules
*/

`timescale 1ns/1ps

module cpu_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_TESTS    = 6;
  localparam int TEST_CYCLES  = 40;
  localparam int TIMEOUT_NS   = (NUM_TESTS * TEST_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  logic           clk;
  logic           arst_n;
  logic           run;
  logic           load_en;
  cpu_pkg::pc_t   load_addr;
  cpu_pkg::word_t load_data;
  cpu_pkg::word_t in_data;
  cpu_pkg::word_t out_data;
  logic           out_valid;

  cpu_pkg::word_t prog_q[$];
  cpu_pkg::word_t outs_q[$];
  cpu_pkg::word_t exp_q[$];

  int error_count;
  int errors_at_start;
  int tests_passed;
  int tests_failed;

  cpu_top cpu_top_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .in_data   (in_data),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // program building

  function automatic cpu_pkg::word_t encode(cpu_pkg::nibble_t opc, cpu_pkg::nibble_t arg);
    return {opc, arg};
  endfunction

  // add, sub and mul keep only the low byte of the full result
  function automatic cpu_pkg::word_t low_byte(logic [15:0] full);
    return full[7:0];
  endfunction

  task automatic emit(cpu_pkg::word_t w);
    prog_q.push_back(w);
  endtask

  // low nibble first, then high nibble
  task automatic emit_byte(cpu_pkg::nibble_t lo_op, cpu_pkg::nibble_t hi_op,
                           cpu_pkg::word_t val);
    emit(encode(lo_op, val[3:0]));
    emit(encode(hi_op, val[7:4]));
  endtask

  ////////////////////
  // stimulus

  task automatic load_program();
    int i;
    run = 1'b0;
    while (prog_q.size() < cpu_pkg::MEM_DEPTH) begin
      prog_q.push_back(encode(cpu_pkg::OP_NOP, 4'h0));
    end
    for (i = 0; i < cpu_pkg::MEM_DEPTH; i++) begin
      load_en   = 1'b1;
      load_addr = cpu_pkg::pc_t'(i);
      load_data = prog_q[i];
      @(negedge clk);
    end
    load_en = 1'b0;
  endtask

  // sampled at the falling edge half a cycle after each executed instruction
  task automatic run_burst(int cycles);
    run = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      if (out_valid) outs_q.push_back(out_data);
    end
    run = 1'b0;
  endtask

  task automatic idle_cycles(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (out_valid) outs_q.push_back(out_data);
    end
  endtask

  task automatic execute();
    run_burst(cpu_pkg::MEM_DEPTH);
  endtask

  ////////////////////
  // checks

  task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
    if (got !== exp) begin
      $display("error: %s = 0x%02h, expected 0x%02h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_outputs();
    int i;
    check_count("out_valid count", outs_q.size(), exp_q.size());
    for (i = 0; i < exp_q.size() && i < outs_q.size(); i++) begin
      check_word($sformatf("out_data[%0d]", i), outs_q[i], exp_q[i]);
    end
  endtask

  task automatic begin_test();
    prog_q.delete();
    outs_q.delete();
    exp_q.delete();
    errors_at_start = error_count;
  endtask

  task automatic finish_test(string name);
    if (error_count == errors_at_start) begin
      tests_passed++;
      $display("test %-16s ok", name);
    end else begin
      tests_failed++;
      $display("test %-16s failed with %0d errors", name, error_count - errors_at_start);
    end
  endtask

  ////////////////////
  // directed tests

  task automatic nibble_load_out();
    cpu_pkg::word_t a, b, c;
    begin_test();
    a = cpu_pkg::word_t'($urandom());
    b = cpu_pkg::word_t'($urandom());
    c = cpu_pkg::word_t'($urandom());
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, a);
    emit_byte(cpu_pkg::OP_LDB_LO, cpu_pkg::OP_LDB_HI, b);
    // C takes its high nibble first so the low load must keep bits 7:4
    emit(encode(cpu_pkg::OP_LDC_HI, c[7:4]));
    emit(encode(cpu_pkg::OP_LDC_LO, c[3:0]));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_A));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_B));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    exp_q.push_back(a);
    exp_q.push_back(b);
    exp_q.push_back(c);
    load_program();
    execute();
    compare_outputs();
    finish_test("nibble loads");
  endtask

  task automatic add_sub_results();
    cpu_pkg::word_t a, b;
    begin_test();
    a = cpu_pkg::word_t'($urandom());
    b = cpu_pkg::word_t'($urandom());
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, a);
    emit_byte(cpu_pkg::OP_LDB_LO, cpu_pkg::OP_LDB_HI, b);
    emit(encode(cpu_pkg::OP_ADD, 4'h0));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    emit(encode(cpu_pkg::OP_SUB, 4'h0));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    exp_q.push_back(low_byte(16'(a) + 16'(b)));
    exp_q.push_back(low_byte(16'(a) - 16'(b)));
    load_program();
    execute();
    compare_outputs();
    finish_test("add and sub");
  endtask

  task automatic mul_overflow();
    cpu_pkg::word_t a, b;
    begin_test();
    a = cpu_pkg::word_t'($urandom());
    b = cpu_pkg::word_t'($urandom());
    // 0x1f * 0x13 = 0x24d and only 0x4d survives
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, 8'h1F);
    emit_byte(cpu_pkg::OP_LDB_LO, cpu_pkg::OP_LDB_HI, 8'h13);
    emit(encode(cpu_pkg::OP_MUL, 4'h0));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, a);
    emit_byte(cpu_pkg::OP_LDB_LO, cpu_pkg::OP_LDB_HI, b);
    emit(encode(cpu_pkg::OP_MUL, 4'h0));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    exp_q.push_back(low_byte(16'h001F * 16'h0013));
    exp_q.push_back(low_byte(16'(a) * 16'(b)));
    load_program();
    execute();
    compare_outputs();
    finish_test("mul");
  endtask

  task automatic in_capture();
    cpu_pkg::word_t a, din;
    begin_test();
    a   = cpu_pkg::word_t'($urandom());
    din = cpu_pkg::word_t'($urandom());
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, a);
    emit(encode(cpu_pkg::OP_IN, cpu_pkg::SEL_B));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_B));
    emit(encode(cpu_pkg::OP_ADD, 4'h0));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    exp_q.push_back(din);
    exp_q.push_back(low_byte(16'(a) + 16'(din)));
    load_program();
    // held steady for the whole run
    in_data = din;
    execute();
    compare_outputs();
    finish_test("in port");
  endtask

  task automatic run_gating();
    cpu_pkg::word_t a, b;
    begin_test();
    a = cpu_pkg::word_t'($urandom());
    b = cpu_pkg::word_t'($urandom());
    in_data = cpu_pkg::word_t'($urandom());
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, a);
    emit_byte(cpu_pkg::OP_LDB_LO, cpu_pkg::OP_LDB_HI, b);
    // undefined opcodes would clobber A or B if they were decoded
    emit(8'hC1);
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_A));
    emit(8'hD2);
    emit(encode(cpu_pkg::OP_ADD, 4'h0));
    // word 8, where pc waits through the idle gap
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    emit(encode(cpu_pkg::OP_OUT, 4'h3));
    emit(8'hE0);
    emit(8'hF7);
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_B));
    emit(encode(cpu_pkg::OP_IN, 4'h3));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_A));
    exp_q.push_back(a);
    exp_q.push_back(low_byte(16'(a) + 16'(b)));
    exp_q.push_back(b);
    exp_q.push_back(a);
    load_program();
    run_burst(8);
    idle_cycles(3);
    run_burst(8);
    compare_outputs();
    finish_test("run gating");
  endtask

  task automatic reset_clear();
    begin_test();
    emit_byte(cpu_pkg::OP_LDA_LO, cpu_pkg::OP_LDA_HI, 8'h5A);
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_A));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_B));
    emit(encode(cpu_pkg::OP_OUT, cpu_pkg::SEL_C));
    load_program();
    arst_n = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    execute();
    compare_outputs();
    check_word("out_data", out_data, 8'h00);
    finish_test("reset clear");
  endtask

  ////////////////////
  // main sequence

  initial begin
    clk             = 1'b0;
    arst_n          = 1'b0;
    run             = 1'b0;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    in_data         = '0;
    error_count     = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    void'($urandom(32'he80f));
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    nibble_load_out();
    add_sub_results();
    mul_overflow();
    in_capture();
    run_gating();
    reset_clear();
    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tb/cpu_checker.sv ====
/*
  cpu checker: concurrent assertions on the program counter
  and the output strobe of the accumulator CPU
*/

`timescale 1ns/1ps

module cpu_checker (
  input logic               clk,
  input logic               arst_n,
  input logic               run,
  input cpu_pkg::pc_t       pc,
  input cpu_pkg::opcode_t   op,
  input logic               out_valid
);

  ////////////////////
  // program counter

  // one step per run cycle, 4-bit wrap from 15 to 0
  pc_advance: assert property (@(posedge clk) disable iff (!arst_n)
    $past(run) |-> (pc == cpu_pkg::pc_t'($past(pc) + 1'b1)))
    else $error("pc did not advance by one after a run cycle");

  pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(run) |-> (pc == $past(pc)))
    else $error("pc moved while run was low");

  ////////////////////
  // output strobe

  valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(out_valid))
    else $error("out_valid is unknown");

  // back to back strobes need two OUTs in a row
  valid_pairs: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && $past(out_valid)) |->
      ($past(op) == cpu_pkg::OP_OUT && $past(op, 2) == cpu_pkg::OP_OUT))
    else $error("out_valid high twice without two OUT instructions");

endmodule

// pc and op are the control block outputs as seen in the top level
bind cpu_top cpu_checker cpu_checker_inst (
  .clk       (clk),
  .arst_n    (arst_n),
  .run       (run),
  .pc        (pc),
  .op        (op),
  .out_valid (out_valid)
);

// ==== design/cpu_top.sv ====
/*
  accumulator CPU top level: program memory, control and datapath
*/

`timescale 1ns/1ps

module cpu_top (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             run,
  input  logic             load_en,
  input  cpu_pkg::pc_t     load_addr,
  input  cpu_pkg::word_t   load_data,
  input  cpu_pkg::word_t   in_data,
  output cpu_pkg::word_t   out_data,
  output logic             out_valid
);

  cpu_pkg::pc_t       pc;
  cpu_pkg::word_t     fetch_word;
  cpu_pkg::opcode_t   op;
  cpu_pkg::nibble_t   operand;

  ////////////////////
  // program store

  program_mem program_mem_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .fetch_addr (pc),
    .fetch_word (fetch_word)
  );

  ////////////////////
  // fetch and decode

  // the only place where run enters the core
  cpu_control cpu_control_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .run        (run),
    .fetch_word (fetch_word),
    .pc         (pc),
    .op         (op),
    .operand    (operand)
  );

  ////////////////////
  // execute

  cpu_datapath cpu_datapath_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .op         (op),
    .operand    (operand),
    .in_data    (in_data),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

endmodule

// ==== design/cpu_datapath.sv ====
/*
  cpu datapath: registers A, B and C, the add/sub/mul ALU,
  IN capture and the registered OUT port with its valid strobe
*/

`timescale 1ns/1ps

module cpu_datapath (
  input  logic               clk,
  input  logic               arst_n,
  input  cpu_pkg::opcode_t   op,
  input  cpu_pkg::nibble_t   operand,
  input  cpu_pkg::word_t     in_data,
  output cpu_pkg::word_t     out_data,
  output logic               out_valid
);

  cpu_pkg::word_t reg_a;
  cpu_pkg::word_t reg_b;
  cpu_pkg::word_t reg_c;

  cpu_pkg::word_t a_next;
  cpu_pkg::word_t b_next;
  cpu_pkg::word_t c_next;
  cpu_pkg::word_t out_next;
  logic           valid_next;

  cpu_pkg::word_t alu_sum;
  cpu_pkg::word_t alu_diff;
  cpu_pkg::word_t alu_prod;

  // nibble replacement, shared by all three registers
  function automatic cpu_pkg::word_t put_lo(cpu_pkg::word_t w, cpu_pkg::nibble_t n);
    return {w[cpu_pkg::DATA_W-1:cpu_pkg::NIB_W], n};
  endfunction

  function automatic cpu_pkg::word_t put_hi(cpu_pkg::word_t w, cpu_pkg::nibble_t n);
    return {n, w[cpu_pkg::NIB_W-1:0]};
  endfunction

  ////////////////////
  // alu

  // all results are 8 bits wide, carries and high product bits drop off
  assign alu_sum  = reg_a + reg_b;
  assign alu_diff = reg_a - reg_b;
  assign alu_prod = reg_a * reg_b;

  ////////////////////
  // next state

  always_comb begin
    a_next     = reg_a;
    b_next     = reg_b;
    c_next     = reg_c;
    out_next   = out_data;
    valid_next = 1'b0;

    case (op)
      cpu_pkg::OP_LDA_LO: a_next = put_lo(reg_a, operand);
      cpu_pkg::OP_LDA_HI: a_next = put_hi(reg_a, operand);
      cpu_pkg::OP_LDB_LO: b_next = put_lo(reg_b, operand);
      cpu_pkg::OP_LDB_HI: b_next = put_hi(reg_b, operand);
      cpu_pkg::OP_LDC_LO: c_next = put_lo(reg_c, operand);
      cpu_pkg::OP_LDC_HI: c_next = put_hi(reg_c, operand);
      cpu_pkg::OP_ADD:    c_next = alu_sum;
      cpu_pkg::OP_SUB:    c_next = alu_diff;
      cpu_pkg::OP_MUL:    c_next = alu_prod;
      cpu_pkg::OP_IN: begin
        // operand above 2 selects nothing
        case (operand)
          cpu_pkg::SEL_A: a_next = in_data;
          cpu_pkg::SEL_B: b_next = in_data;
          cpu_pkg::SEL_C: c_next = in_data;
          default: ;
        endcase
      end
      cpu_pkg::OP_OUT: begin
        valid_next = 1'b1;
        case (operand)
          cpu_pkg::SEL_A: out_next = reg_a;
          cpu_pkg::SEL_B: out_next = reg_b;
          cpu_pkg::SEL_C: out_next = reg_c;
          default:        valid_next = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  ////////////////////
  // registers

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a     <= '0;
      reg_b     <= '0;
      reg_c     <= '0;
      out_data  <= '0;
      out_valid <= 1'b0;
    end else begin
      reg_a     <= a_next;
      reg_b     <= b_next;
      reg_c     <= c_next;
      out_data  <= out_next;
      // one-cycle strobe per executed OUT
      out_valid <= valid_next;
    end
  end

endmodule

// ==== design/cpu_control.sv ====
/*
  cpu control: program counter, instruction split and opcode decode.
  run gates both the counter and the decoded operation
*/

`timescale 1ns/1ps

module cpu_control (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               run,
  input  cpu_pkg::word_t     fetch_word,
  output cpu_pkg::pc_t       pc,
  output cpu_pkg::opcode_t   op,
  output cpu_pkg::nibble_t   operand
);

  cpu_pkg::nibble_t raw_op;
  cpu_pkg::pc_t     pc_next;
  logic             op_defined;

  ////////////////////
  // program counter

  // 4-bit counter, wraps from 15 back to 0 on its own
  assign pc_next = pc + 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= pc_next;
    end
  end

  ////////////////////
  // instruction split

  assign raw_op  = fetch_word[cpu_pkg::DATA_W-1:cpu_pkg::NIB_W];
  assign operand = fetch_word[cpu_pkg::NIB_W-1:0];

  ////////////////////
  // opcode decode

  // only 0x0 to 0xB carry meaning
  always_comb begin
    case (raw_op)
      cpu_pkg::OP_NOP,
      cpu_pkg::OP_LDA_LO,
      cpu_pkg::OP_LDA_HI,
      cpu_pkg::OP_LDB_LO,
      cpu_pkg::OP_LDB_HI,
      cpu_pkg::OP_LDC_LO,
      cpu_pkg::OP_LDC_HI,
      cpu_pkg::OP_ADD,
      cpu_pkg::OP_SUB,
      cpu_pkg::OP_MUL,
      cpu_pkg::OP_OUT,
      cpu_pkg::OP_IN: op_defined = 1'b1;
      default:        op_defined = 1'b0;
    endcase
  end

  // the datapath never looks at run, a stopped CPU just sees NOP
  always_comb begin
    if (run && op_defined) begin
      op = cpu_pkg::opcode_t'(raw_op);
    end else begin
      op = cpu_pkg::OP_NOP;
    end
  end

endmodule

// ==== design/program_mem.sv ====
/*
  program memory: sixteen instruction words in flip-flops,
  written through a strobed load port and read combinationally
*/

`timescale 1ns/1ps

module program_mem (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           load_en,
  input  cpu_pkg::pc_t   load_addr,
  input  cpu_pkg::word_t load_data,
  input  cpu_pkg::pc_t   fetch_addr,
  output cpu_pkg::word_t fetch_word
);

  cpu_pkg::word_t mem [cpu_pkg::MEM_DEPTH];

  ////////////////////
  // write port

  // reset wipes the whole program, so a reset CPU only runs NOPs
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < cpu_pkg::MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  ////////////////////
  // fetch port

  // no read latency, the control block decodes in the same cycle
  assign fetch_word = mem[fetch_addr];

endmodule

// ==== design/cpu_pkg.sv ====
/*
  cpu package: word, nibble and address widths, their vector types
  and the instruction opcodes of the accumulator CPU
*/

package cpu_pkg;

  ////////////////////
  // widths fixed by the instruction format

  // register and memory word
  localparam int DATA_W    = 8;
  // operand nibble, also the opcode field
  localparam int NIB_W     = 4;
  // program counter and memory address
  localparam int ADDR_W    = 4;
  localparam int MEM_DEPTH = 16;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [NIB_W-1:0]  nibble_t;
  typedef logic [ADDR_W-1:0] pc_t;

  ////////////////////
  // opcodes, upper nibble of the instruction word
  // 0xC to 0xF are undefined and decode as NOP

  typedef enum logic [NIB_W-1:0] {
    OP_NOP    = 4'h0,
    OP_LDA_LO = 4'h1,
    OP_LDA_HI = 4'h2,
    OP_LDB_LO = 4'h3,
    OP_LDB_HI = 4'h4,
    OP_LDC_LO = 4'h5,
    OP_LDC_HI = 4'h6,
    OP_ADD    = 4'h7,
    OP_SUB    = 4'h8,
    OP_MUL    = 4'h9,
    OP_OUT    = 4'hA,
    OP_IN     = 4'hB
  } opcode_t;

  // register select for IN and OUT, taken from the operand
  localparam nibble_t SEL_A = 4'd0;
  localparam nibble_t SEL_B = 4'd1;
  localparam nibble_t SEL_C = 4'd2;

endpackage
